/* mips_exec_trace.txt */
// instr    flags: illegal, jump_valid, wb_en digits then wb_reg byte    value    name
// value is wb_data when wb_en is set, jump_target when jump_valid is set
00655020 0010a 00000008 00
00675822 0010b fffffffc 01
01ae8024 00110 0000000c 02
01268825 00111 0000000f 03
0163902a 00112 00000001 04
006b982a 00113 00000000 05
20b4fff9 00114 fffffffe 06
32958f0f 00115 00008f0e 07
34768001 00116 00008003 08
3c17abcd 00117 abcd0000 09
72cbc002 00118 fffdfff4 0a
72e7c802 00119 b29b0000 0b
00650020 00000 00000000 0c
0009d020 0011a 00000009 0d
0150d820 0011b 00000014 0e
02e00008 01000 abcd0000 0f
02e0e020 0011c abcd0000 10
8d1d0004 10000 00000000 11
03a0f020 0011e 0000001d 12
0005f802 10000 00000000 13
03e00820 00101 0000001f 14

/* files.f */
mips_isa_pkg.sv
exec_ctrl_pkg.sv
register_bank.sv
instr_decoder.sv
alu_unit.sv
shift_add_multiplier.sv
step_timer.sv
exec_fsm.sv
mips_exec_top.sv
tb_mips_exec.sv

/* tb_mips_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_mips_exec
	import mips_isa_pkg::*;
;

	localparam int mult_steps     = 32;	// Multiply length in the DUT
	localparam int num_tests      = 21;	// Entries in the trace file
	localparam int trace_words    = num_tests * 4;	// Four columns per entry
	localparam int timeout_cycles = num_tests * (mult_steps + 8) + 50;

	logic      clk;
	logic      reset;
	logic      instr_valid;
	word_t     instr;
	logic      busy;
	logic      done;
	logic      wb_en;
	reg_addr_t wb_reg;
	word_t     wb_data;
	logic      jump_valid;
	word_t     jump_target;
	logic      illegal;

	logic [31:0] trace_mem [0:trace_words-1];	// instr, flags, value, name index
	logic [31:0] lfsr_state;	// Idle gap source
	int          cycle_count;	// Watchdog count
	int          test_errors;	// Failed checks in the current test
	int          passed_tests;
	int          failed_tests;

	mips_exec_top #(
		.data_width(32),
		.reg_count(32),
		.mult_steps(mult_steps)
	) dut_i (
		.clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
		.busy(busy), .done(done), .wb_en(wb_en), .wb_reg(wb_reg),
		.wb_data(wb_data), .jump_valid(jump_valid), .jump_target(jump_target),
		.illegal(illegal)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;	// 100 ns period
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////

	// Galois form, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic [31:0] next;
		next = state >> 1;
		if (state[0])
			next = next ^ 32'h80200003;
		return next;
	endfunction

	function automatic string test_name(input int idx);
		case (idx)
			0:       return "add";
			1:       return "sub";
			2:       return "and";
			3:       return "or";
			4:       return "slt_negative_lt";
			5:       return "slt_positive_ge";
			6:       return "addi_negative";
			7:       return "andi_zero_ext";
			8:       return "ori_zero_ext";
			9:       return "lui";
			10:      return "mul_wrap";
			11:      return "mul_upper";
			12:      return "write_r0";
			13:      return "read_r0";
			14:      return "read_back";
			15:      return "jr";
			16:      return "jr_no_write";
			17:      return "illegal_opcode";
			18:      return "illegal_opcode_no_write";
			19:      return "illegal_funct";
			20:      return "illegal_funct_no_write";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_value(input string name, input string what,
		input logic [31:0] expected, input logic [31:0] actual);
		assert (actual === expected)
		else
		begin
			$display("CHECK FAILED %s %s: expected %h, actual %h", name, what,
				expected, actual);
			test_errors++;
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0)
		begin
			$display("%-24s ok", name);
			passed_tests++;
		end
		else
		begin
			$display("%-24s FAILED with %0d bad check(s)", name, test_errors);
			failed_tests++;
		end
		test_errors = 0;
	endtask

	// Two LFSR bits give 0 to 3 idle cycles
	task automatic draw_idle_gap(output int gap);
		logic b0;
		logic b1;
		b0         = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
		b1         = lfsr_state[0];
		lfsr_state = lfsr_next(lfsr_state);
		gap        = {b1, b0};
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One trace entry, strobe to done
	////////////////////////////////////////////////////////////////////////////

	task automatic run_test(input int idx);
		word_t       instr_word;
		logic [31:0] flags;
		logic [31:0] exp_value;
		string       name;
		int          latency;
		int          exp_latency;
		int          gap;
		logic        is_mul_word;
		instr_word  = trace_mem[idx*4];
		flags       = trace_mem[idx*4+1];
		exp_value   = trace_mem[idx*4+2];
		name        = test_name(int'(trace_mem[idx*4+3]));
		is_mul_word = (instr_word[31:26] == OP_SPECIAL2) && (instr_word[5:0] == FN_MUL);
		exp_latency = is_mul_word ? 3 + mult_steps : 3;	// Read, exec, write

		@(posedge clk);	// Cycle 0 starts here
		instr       <= instr_word;
		instr_valid <= 1'b1;
		@(posedge clk);	// Accept edge
		instr_valid <= 1'b0;
		latency = 1;
		@(negedge clk);
		while (!done)
		begin
			check_value(name, "busy", 1, busy);	// Held until done
			@(negedge clk);
			latency++;
		end

		check_value(name, "busy", 1, busy);
		check_value(name, "latency", exp_latency, latency);
		check_value(name, "wb_en", flags[8], wb_en);
		check_value(name, "jump_valid", flags[12], jump_valid);
		check_value(name, "illegal", flags[16], illegal);
		if (flags[8])
		begin
			check_value(name, "wb_reg", flags[4:0], wb_reg);
			check_value(name, "wb_data", exp_value, wb_data);
		end
		if (flags[12])
			check_value(name, "jump_target", exp_value, jump_target);
		report_test(name);

		draw_idle_gap(gap);
		repeat (gap) @(posedge clk);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence and watchdog
	////////////////////////////////////////////////////////////////////////////

	initial
	begin
		logic load_error;
		reset        = 1'b1;
		instr_valid  = 1'b0;
		instr        = '0;
		lfsr_state   = 32'h9587543e;
		test_errors  = 0;
		passed_tests = 0;
		failed_tests = 0;
		load_error   = 1'b0;
		$readmemh("mips_exec_trace.txt", trace_mem);
		assert (!$isunknown(trace_mem[trace_words-1]))
		else
		begin
			$display("ERROR: trace file mips_exec_trace.txt is missing or short");
			load_error = 1'b1;
		end

		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("reset", "busy", 0, busy);	// All completion flags clear
		check_value("reset", "done", 0, done);
		check_value("reset", "wb_en", 0, wb_en);
		check_value("reset", "jump_valid", 0, jump_valid);
		check_value("reset", "illegal", 0, illegal);
		report_test("reset");

		if (!load_error)
		begin
			for (int i = 0; i < num_tests; i++)
				run_test(i);
		end

		$display("Tests: %0d passed, %0d failed", passed_tests, failed_tests);
		if ((failed_tests == 0) && !load_error)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

	initial
	begin
		cycle_count = 0;
		while (cycle_count < timeout_cycles)
		begin
			@(posedge clk);
			cycle_count++;
		end
		$display("ERROR: timeout, done never arrived within %0d cycles", timeout_cycles);
		$display("Done: errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* mips_exec_top.sv */
`timescale 1ns/1ps
`default_nettype none

module mips_exec_top
	import mips_isa_pkg::*;
	import exec_ctrl_pkg::*;
#(
	parameter int data_width = 32,	// Word width
	parameter int reg_count  = 32,	// Register bank depth
	parameter int mult_steps = data_width	// One step per multiplier bit
)
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  instr_valid,
	input  wire word_t instr,
	output logic       busy,
	output logic       done,
	output logic       wb_en,
	output reg_addr_t  wb_reg,
	output word_t      wb_data,
	output logic       jump_valid,
	output word_t      jump_target,
	output logic       illegal
);

	word_t       instr_q;	// Instruction held for the whole run
	word_t       jump_q;	// rs value sampled in READ
	logic        instr_latch;
	logic        rd_en;
	logic        mult_start;
	logic        mult_step;
	logic        timer_load;
	logic        timer_expired;
	logic        wr_en;
	step_count_t timer_count;
	reg_addr_t   rs_addr;
	reg_addr_t   rt_addr;
	reg_addr_t   dest_addr;
	word_t       imm_value;
	word_t       rs_data;
	word_t       rt_data;
	word_t       jump_data;
	word_t       alu_b;
	word_t       alu_result;
	word_t       product;
	logic        use_imm;
	logic        is_mul;
	logic        is_jr;
	logic        writes_reg;
	logic        dec_illegal;
	alu_op_t     alu_op;

	always_ff @(posedge clk)
	begin
		if (instr_latch)
			instr_q <= instr;	// Accept edge
		if (rd_en)
			jump_q <= jump_data;	// Same edge as the read ports
	end

	assign alu_b       = use_imm ? imm_value : rt_data;
	assign wb_data     = is_mul ? product : alu_result;	// Also the write data
	assign wb_reg      = dest_addr;
	assign jump_target = jump_q;

	exec_fsm #(.mult_steps(mult_steps)) fsm_i (
		.clk(clk), .reset(reset), .instr_valid(instr_valid),
		.is_mul(is_mul), .is_jr(is_jr), .writes_reg(writes_reg),
		.illegal(dec_illegal), .timer_expired(timer_expired),
		.instr_latch(instr_latch), .rd_en(rd_en), .mult_start(mult_start),
		.mult_step(mult_step), .timer_load(timer_load), .wr_en(wr_en),
		.timer_count(timer_count), .busy(busy), .done(done), .wb_en(wb_en),
		.jump_valid(jump_valid), .illegal_out(illegal)
	);

	step_timer timer_i (
		.clk(clk), .reset(reset), .load(timer_load), .count(timer_count),
		.expired(timer_expired)
	);

	instr_decoder decoder_i (
		.instr(instr_q), .rs_addr(rs_addr), .rt_addr(rt_addr),
		.dest_addr(dest_addr), .imm_value(imm_value), .use_imm(use_imm),
		.is_mul(is_mul), .is_jr(is_jr), .writes_reg(writes_reg),
		.illegal(dec_illegal), .alu_op(alu_op)
	);

	register_bank #(.data_width(data_width), .reg_count(reg_count)) bank_i (
		.clk(clk), .reset(reset), .rd_en(rd_en), .rs_addr(rs_addr),
		.rt_addr(rt_addr), .wr_addr(dest_addr), .wr_en(wr_en),
		.wr_data(wb_data), .rs_data(rs_data), .rt_data(rt_data),
		.jump_data(jump_data)
	);

	alu_unit #(.data_width(data_width)) alu_i (
		.a(rs_data), .b(alu_b), .op(alu_op), .result(alu_result)
	);

	shift_add_multiplier #(.data_width(data_width)) mult_i (
		.clk(clk), .reset(reset), .start(mult_start), .step(mult_step),
		.multiplicand(rs_data), .multiplier(rt_data), .product(product)
	);

endmodule

`default_nettype wire

/* exec_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_fsm
	import exec_ctrl_pkg::*;
#(
	parameter int mult_steps = 32	// Cycles spent in MULT
)
(
	input  wire logic clk,
	input  wire logic reset,
	input  wire logic instr_valid,	// Single-cycle strobe
	input  wire logic is_mul,	// Decoder flags
	input  wire logic is_jr,
	input  wire logic writes_reg,
	input  wire logic illegal,
	input  wire logic timer_expired,
	output logic      instr_latch,	// Load instruction register
	output logic      rd_en,
	output logic      mult_start,
	output logic      mult_step,
	output logic      timer_load,
	output logic      wr_en,
	output step_count_t timer_count,
	output logic      busy,
	output logic      done,
	output logic      wb_en,
	output logic      jump_valid,
	output logic      illegal_out
);

	exec_state_t state_q;
	exec_state_t state_d;
	logic        mul_q;	// Latched decoder flags
	logic        jr_q;
	logic        wr_q;
	logic        illegal_q;

	always_ff @(posedge clk)
	begin
		if (reset)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	// Captured in READ, the first cycle the instruction register is valid
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mul_q     <= 1'b0;
			jr_q      <= 1'b0;
			wr_q      <= 1'b0;
			illegal_q <= 1'b0;
		end
		else if (state_q == READ)
		begin
			mul_q     <= is_mul;
			jr_q      <= is_jr;
			wr_q      <= writes_reg;
			illegal_q <= illegal;
		end
	end

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
				if (instr_valid)
					state_d = READ;
			READ:    state_d = EXEC;
			EXEC:    state_d = mul_q ? MULT : WRITE;
			MULT:
				if (timer_expired)
					state_d = WRITE;	// Last partial product in
			WRITE:   state_d = IDLE;
			default: state_d = IDLE;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Datapath controls and completion outputs
	////////////////////////////////////////////////////////////////////////////

	assign instr_latch = (state_q == IDLE) && instr_valid;	// Strobes while busy ignored
	assign rd_en       = (state_q == READ);
	assign mult_start  = (state_q == EXEC) && mul_q;
	assign timer_load  = (state_q == EXEC) && mul_q;	// On EXEC to MULT
	assign timer_count = step_count_t'(mult_steps);
	assign mult_step   = (state_q == MULT);
	assign wr_en       = (state_q == WRITE) && wr_q;
	assign busy        = (state_q != IDLE);	// Through the done cycle
	assign done        = (state_q == WRITE);
	assign wb_en       = wr_en;
	assign jump_valid  = (state_q == WRITE) && jr_q;
	assign illegal_out = (state_q == WRITE) && illegal_q;

	// No back-pressure, so the environment has to wait out busy
	assert property (@(posedge clk) disable iff (reset) busy |-> !instr_valid)
		else $error("exec_fsm: instr_valid while busy");

	// Timer expiry belongs to the multiply phase only
	assert property (@(posedge clk) disable iff (reset)
		timer_expired |-> (state_q == MULT))
		else $error("exec_fsm: timer expired outside MULT");

endmodule

`default_nettype wire

/* step_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module step_timer
	import exec_ctrl_pkg::*;
(
	input  wire logic        clk,
	input  wire logic        reset,
	input  wire logic        load,	// Start a new count
	input  wire step_count_t count,	// Cycles until the pulse sequence ends
	output logic             expired	// High during the last counted cycle
);

	step_count_t count_q;	// Zero when idle

	always_ff @(posedge clk)
	begin
		if (reset)
			count_q <= '0;
		else if (load)
			count_q <= count;
		else if (count_q != '0)
			count_q <= count_q - 1'b1;	// Holds at zero afterwards
	end

	assign expired = (count_q == step_count_t'(1));

	// A new multiply may only start after the previous one has drained
	assert property (@(posedge clk) disable iff (reset) load |-> (count_q == '0))
		else $error("step_timer: load while counting");

endmodule

`default_nettype wire

/* shift_add_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module shift_add_multiplier
	import mips_isa_pkg::*;
#(
	parameter int data_width = 32	// Operand and product width
)
(
	input  wire logic  clk,
	input  wire logic  reset,
	input  wire logic  start,	// Load operands, clear accumulator
	input  wire logic  step,	// One partial product
	input  wire word_t multiplicand,
	input  wire word_t multiplier,
	output word_t      product	// Low word of the running sum
);

	logic [data_width-1:0] mcand_q;	// Shifts left each step
	logic [data_width-1:0] mplier_q;	// Shifts right, bit 0 is current
	logic [data_width-1:0] acc_q;	// Partial sum, upper bits discarded

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			mcand_q  <= '0;
			mplier_q <= '0;
			acc_q    <= '0;
		end
		else if (start)
		begin
			mcand_q  <= multiplicand;
			mplier_q <= multiplier;
			acc_q    <= '0;
		end
		else if (step)
		begin
			if (mplier_q[0])
			begin
				acc_q <= acc_q + mcand_q;	// Add weighted multiplicand
			end
			mcand_q  <= mcand_q << 1;	// Next bit weight
			mplier_q <= mplier_q >> 1;
		end
	end

	assign product = acc_q;	// Valid after data_width steps

endmodule

`default_nettype wire

/* alu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module alu_unit
	import mips_isa_pkg::*;
	import exec_ctrl_pkg::*;
#(
	parameter int data_width = 32	// Operand width
)
(
	input  wire word_t   a,	// rs value
	input  wire word_t   b,	// rt value or immediate
	input  var  alu_op_t op,
	output word_t        result
);

	localparam int half_width = data_width / 2;	// lui shift amount

	word_t sum;
	word_t diff;
	logic  less;	// Signed a < b

	assign sum  = a + b;	// Wraps modulo 2^32
	assign diff = a - b;

	// Differing signs decide directly, otherwise the difference sign does
	assign less = (a[data_width-1] != b[data_width-1]) ? a[data_width-1]
		: diff[data_width-1];

	always_comb
	begin
		case (op)
			ADD:     result = sum;
			SUB:     result = diff;
			AND:     result = a & b;
			OR:      result = a | b;
			SLT:     result = {{(data_width-1){1'b0}}, less};	// 1 or 0
			LUI:     result = b << half_width;	// Low half cleared
			default: result = sum;
		endcase
	end

endmodule

`default_nettype wire

/* instr_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_decoder
	import mips_isa_pkg::*;
	import exec_ctrl_pkg::*;
(
	input  wire word_t instr,
	output reg_addr_t  rs_addr,
	output reg_addr_t  rt_addr,
	output reg_addr_t  dest_addr,	// rd for R-type, rt for I-type
	output word_t      imm_value,	// Extended immediate
	output logic       use_imm,	// ALU b from immediate
	output logic       is_mul,
	output logic       is_jr,
	output logic       writes_reg,	// Real writeback, never to $zero
	output logic       illegal,
	output alu_op_t    alu_op
);

	opcode_t     opcode;
	funct_t      funct;
	reg_addr_t   rd_field;
	logic [15:0] imm_field;
	logic        has_dest;	// Encoding names a destination

	// Fixed field positions
	assign opcode    = instr[31:26];
	assign rs_addr   = instr[25:21];
	assign rt_addr   = instr[20:16];
	assign rd_field  = instr[15:11];
	assign funct     = instr[5:0];
	assign imm_field = instr[15:0];

	always_comb
	begin
		alu_op    = ADD;
		imm_value = {16'b0, imm_field};	// Zero extension unless addi
		use_imm   = 1'b0;
		is_mul    = 1'b0;
		is_jr     = 1'b0;
		illegal   = 1'b0;
		has_dest  = 1'b1;
		dest_addr = rd_field;
		case (opcode)
			OP_RTYPE:
				case (funct)
					FN_ADD: alu_op = ADD;
					FN_SUB: alu_op = SUB;
					FN_AND: alu_op = AND;
					FN_OR:  alu_op = OR;
					FN_SLT: alu_op = SLT;
					FN_JR:
					begin
						is_jr    = 1'b1;	// Target comes from rs
						has_dest = 1'b0;
					end
					default: illegal = 1'b1;	// addu, shifts and the rest
				endcase
			OP_SPECIAL2:
				if (funct == FN_MUL)
					is_mul = 1'b1;	// Result into rd
				else
					illegal = 1'b1;
			OP_ADDI:
			begin
				imm_value = {{16{imm_field[15]}}, imm_field};	// Sign extend
				use_imm   = 1'b1;
				dest_addr = rt_addr;
			end
			OP_ANDI:
			begin
				alu_op    = AND;
				use_imm   = 1'b1;
				dest_addr = rt_addr;
			end
			OP_ORI:
			begin
				alu_op    = OR;
				use_imm   = 1'b1;
				dest_addr = rt_addr;
			end
			OP_LUI:
			begin
				alu_op    = LUI;	// Shift done in the ALU
				use_imm   = 1'b1;
				dest_addr = rt_addr;
			end
			default: illegal = 1'b1;
		endcase
	end

	// Illegal words and $zero destinations leave the bank untouched
	assign writes_reg = has_dest && !illegal && (dest_addr != '0);

endmodule

`default_nettype wire

/* register_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module register_bank
	import mips_isa_pkg::*;
#(
	parameter int data_width = 32,	// Bits per entry
	parameter int reg_count  = 32	// Number of entries
)
(
	input  wire logic      clk,
	input  wire logic      reset,
	input  wire logic      rd_en,	// Capture both read ports
	input  wire reg_addr_t rs_addr,
	input  wire reg_addr_t rt_addr,
	input  wire reg_addr_t wr_addr,
	input  wire logic      wr_en,	// One-cycle writeback strobe
	input  wire word_t     wr_data,
	output word_t          rs_data,	// Registered
	output word_t          rt_data,	// Registered
	output word_t          jump_data	// Combinational rs value for jr
);

	logic [data_width-1:0] regs [reg_count];	// Storage array

	// Register 0 is hardwired, so the array entry is never consulted
	assign jump_data = (rs_addr == '0) ? '0 : regs[rs_addr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < reg_count; i++)
			begin
				regs[i] <= data_width'(i);	// Entry i starts as i
			end
			rs_data <= '0;
			rt_data <= '0;
		end
		else
		begin
			if (rd_en)
			begin
				rs_data <= (rs_addr == '0) ? '0 : regs[rs_addr];	// Zero reg
				rt_data <= (rt_addr == '0) ? '0 : regs[rt_addr];
			end
			if (wr_en && (wr_addr != '0))	// Writes to $zero dropped
			begin
				regs[wr_addr] <= wr_data;
			end
		end
	end

	// FSM must not strobe a writeback while the bank is being initialized
	assert property (@(posedge clk) wr_en |-> !reset)
		else $error("register_bank: write strobe during reset");

endmodule

`default_nettype wire

/* exec_ctrl_pkg.sv */
`default_nettype none

package exec_ctrl_pkg;

	// Engine sequencing, one instruction in flight
	typedef enum logic [2:0]
	{
		IDLE,	// Waiting for instr_valid
		READ,	// Register bank captures rs and rt
		EXEC,	// ALU result settles, multiplier loads
		MULT,	// One partial product per cycle
		WRITE	// Writeback and done
	} exec_state_t;

	// ALU function select
	typedef enum logic [2:0]
	{
		ADD,
		SUB,
		AND,
		OR,
		SLT,
		LUI	// b moved to the upper half
	} alu_op_t;

	localparam int STEP_COUNT_W = 6;	// Enough for 32 multiply steps

	typedef logic [STEP_COUNT_W-1:0] step_count_t;	// Timer load value

endpackage

`default_nettype wire

/* mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Field widths of the MIPS32 instruction word
	////////////////////////////////////////////////////////////////////////////

	localparam int WORD_WIDTH  = 32;	// Data path and instruction width
	localparam int REG_ADDR_W  = 5;	// 32 architectural registers
	localparam int FIELD_W     = 6;	// Opcode and funct are both 6 bits

	typedef logic [WORD_WIDTH-1:0] word_t;	// Register value or instruction
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;	// rs, rt or rd index
	typedef logic [FIELD_W-1:0]    opcode_t;	// Bits 31:26
	typedef logic [FIELD_W-1:0]    funct_t;	// Bits 5:0, R-type only

	////////////////////////////////////////////////////////////////////////////
	// Major opcodes
	////////////////////////////////////////////////////////////////////////////

	localparam opcode_t OP_RTYPE    = 6'h00;	// SPECIAL, decoded by funct
	localparam opcode_t OP_SPECIAL2 = 6'h1c;	// Holds the three-operand mul
	localparam opcode_t OP_ADDI     = 6'h08;	// Sign-extended immediate
	localparam opcode_t OP_ANDI     = 6'h0c;	// Zero-extended immediate
	localparam opcode_t OP_ORI      = 6'h0d;	// Zero-extended immediate
	localparam opcode_t OP_LUI      = 6'h0f;	// Immediate to upper half

	////////////////////////////////////////////////////////////////////////////
	// Function codes
	////////////////////////////////////////////////////////////////////////////

	localparam funct_t FN_ADD = 6'h20;	// Wraps here, no overflow trap
	localparam funct_t FN_SUB = 6'h22;
	localparam funct_t FN_AND = 6'h24;
	localparam funct_t FN_OR  = 6'h25;
	localparam funct_t FN_SLT = 6'h2a;	// Signed compare
	localparam funct_t FN_JR  = 6'h08;	// Jump to rs
	localparam funct_t FN_MUL = 6'h02;	// Under OP_SPECIAL2, low word kept

endpackage

`default_nettype wire
